// ==== vlog.f ====
src/ro_cache_pkg.sv
src/ro_cache_select.sv
src/ro_cache_lookup.sv
src/ro_cache_refill.sv
src/ro_cache_top.sv
tests/ro_cache_assert.sv
tests/ro_cache_tb.sv

// ==== Bender.yml ====
package:
  name: ro_cache

sources:
  - files:
      - src/ro_cache_pkg.sv
      - src/ro_cache_select.sv
      - src/ro_cache_lookup.sv
      - src/ro_cache_refill.sv
      - src/ro_cache_top.sv
  - target: test
    files:
      - tests/ro_cache_assert.sv
      - tests/ro_cache_tb.sv

// ==== tests/ro_cache_tb.sv ====
module ro_cache_tb;

  localparam int unsigned LineCount   = 16;
  localparam int unsigned NrAddrRules = 2;
  localparam int unsigned NumRandom   = 200;
  localparam int unsigned NumReqs     = 8 + 8 + 3 + NumRandom + 1;
  localparam logic [31:0] Seed        = 32'h8074_e13f;

  logic                                  clk_i = 1'b0;
  logic                                  rst_i;
  logic                                  enable_i;
  ro_cache_pkg::addr_t [NrAddrRules-1:0] start_addr_i;
  ro_cache_pkg::addr_t [NrAddrRules-1:0] end_addr_i;
  logic                                  flush_valid_i;
  logic                                  flush_ready_o;
  logic                                  req_valid_i;
  logic                                  req_ready_o;
  ro_cache_pkg::addr_t                   req_addr_i;
  logic                                  req_write_i;
  ro_cache_pkg::data_t                   req_wdata_i;
  logic                                  rsp_valid_o;
  logic                                  rsp_ready_i;
  ro_cache_pkg::data_t                   rsp_data_o;
  logic                                  mem_req_valid_o;
  logic                                  mem_req_ready_i;
  ro_cache_pkg::addr_t                   mem_req_addr_o;
  logic                                  mem_req_write_o;
  ro_cache_pkg::data_t                   mem_req_wdata_o;
  logic                                  mem_rsp_valid_i;
  ro_cache_pkg::data_t                   mem_rsp_data_i;

  // Memory model and reference state
  ro_cache_pkg::data_t mem        [256];
  ro_cache_pkg::data_t ref_mem    [256];
  ro_cache_pkg::line_t shadow     [64];
  logic                ref_valid  [64];
  ro_cache_pkg::data_t exp_q      [$];
  ro_cache_pkg::data_t mem_pend_q [$];

  logic [31:0]         stim_rng = Seed;
  logic [31:0]         drv_rng  = Seed ^ 32'h0000_ffff;
  logic                bp_en    = 1'b0;
  logic [1:0]          lat_cnt  = 2'd0;
  int unsigned         mem_reads;
  int unsigned         mem_writes;
  int unsigned         rd_sent;
  int unsigned         wr_sent;
  int unsigned         rsp_cnt;
  int unsigned         err_cnt;
  int unsigned         checks;
  int unsigned         test_num;
  int unsigned         test_err0;
  int unsigned         rd_base;
  int unsigned         wr_base;
  int unsigned         lat;
  ro_cache_pkg::addr_t addr;
  logic                is_wr;

  ro_cache_top #(
    .LineCount   ( LineCount   ),
    .NrAddrRules ( NrAddrRules )
  ) DUT (.*);

  always #2 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic in_region(input ro_cache_pkg::addr_t a);
    for (int r = 0; r < NrAddrRules; r++) begin
      if (a >= start_addr_i[r] && a < end_addr_i[r]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Regions cover 16 lines on distinct indices, so no line is ever evicted
  function automatic ro_cache_pkg::data_t expected_read(input ro_cache_pkg::addr_t a);
    logic [5:0] line;
    line = a[9:4];
    if (!enable_i || !in_region(a)) begin
      return ref_mem[a[9:2]];
    end
    if (!ref_valid[line]) begin
      for (int w = 0; w < 4; w++) begin
        shadow[line][w] = ref_mem[{line, w[1:0]}];
      end
      ref_valid[line] = 1'b1;
    end
    return shadow[line][a[3:2]];
  endfunction

  task automatic check_data(input string name, input ro_cache_pkg::data_t got,
                            input ro_cache_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    checks++;
    if (got != exp) begin
      err_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input ro_cache_pkg::addr_t a, input logic wr,
                          input ro_cache_pkg::data_t wdata);
    req_valid_i = 1'b1;
    req_addr_i  = a;
    req_write_i = wr;
    req_wdata_i = wdata;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    if (wr) begin
      ref_mem[a[9:2]] = wdata;
      wr_sent++;
    end else begin
      exp_q.push_back(expected_read(a));
      rd_sent++;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic read_line(input ro_cache_pkg::addr_t base);
    for (int w = 0; w < 4; w++) begin
      send_req(base + ro_cache_pkg::addr_t'(4 * w), 1'b0, '0);
    end
  endtask

  // All reads answered and all writes seen by memory
  task automatic wait_idle();
    while (exp_q.size() != 0 || mem_writes != wr_sent) @(negedge clk_i);
  endtask

  task automatic flush_cache();
    flush_valid_i = 1'b1;
    @(posedge clk_i);
    while (!flush_ready_o) @(posedge clk_i);
    for (int l = 0; l < 64; l++) begin
      ref_valid[l] = 1'b0;
    end
    @(negedge clk_i);
    flush_valid_i = 1'b0;
  endtask

  // --------------------
  // Memory and ready drivers
  // --------------------
  always @(posedge clk_i) begin
    if (!rst_i && mem_req_valid_o && mem_req_ready_i) begin
      if (mem_req_write_o) begin
        mem[mem_req_addr_o[9:2]] = mem_req_wdata_o;
        mem_writes++;
      end else begin
        mem_pend_q.push_back(mem[mem_req_addr_o[9:2]]);
        mem_reads++;
      end
    end
  end

  always @(negedge clk_i) begin
    drv_rng         = lcg_next(drv_rng);
    rsp_ready_i     = !bp_en || (drv_rng[31:30] != 2'b00);
    mem_req_ready_i = !bp_en || (drv_rng[29:28] != 2'b00);
    mem_rsp_valid_i = 1'b0;
    if (mem_pend_q.size() > 0) begin
      if (lat_cnt == 2'd0) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_data_i  = mem_pend_q.pop_front();
        lat_cnt         = drv_rng[25:24];
      end else begin
        lat_cnt--;
      end
    end
  end

  // Compare process
  always @(posedge clk_i) begin
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected response with no read outstanding");
      end else begin
        check_data("rsp_data_o", rsp_data_o, exp_q.pop_front());
      end
    end
  end

  initial begin
    repeat (NumReqs * 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run did not finish", NumReqs * 200);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    rst_i           = 1'b1;
    enable_i        = 1'b1;
    flush_valid_i   = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_write_i     = 1'b0;
    req_wdata_i     = '0;
    rsp_ready_i     = 1'b1;
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    start_addr_i[0] = 32'h0000_0000;
    end_addr_i[0]   = 32'h0000_0080;
    start_addr_i[1] = 32'h0000_0180;
    end_addr_i[1]   = 32'h0000_0200;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 32'ha5c3_0000 ^ ((i << 2) * 32'h0001_0001);
      ref_mem[i] = mem[i];
    end
    for (int l = 0; l < 64; l++) begin
      ref_valid[l] = 1'b0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    rd_base = mem_reads;
    read_line(32'h0000_0040);
    wait_idle();
    check_count("line refill reads", mem_reads - rd_base, 4);
    rd_base = mem_reads;
    read_line(32'h0000_0040);
    wait_idle();
    check_count("second pass reads", mem_reads - rd_base, 0);
    report_test("cached line read");

    rd_base = mem_reads;
    read_line(32'h0000_0100);
    enable_i = 1'b0;
    read_line(32'h0000_0040);
    wait_idle();
    enable_i = 1'b1;
    check_count("bypass reads", mem_reads - rd_base, 8);
    report_test("bypass reads");

    rd_base = mem_reads;
    wr_base = mem_writes;
    send_req(32'h0000_0044, 1'b1, 32'hfeed_0044);
    send_req(32'h0000_0044, 1'b0, '0);
    wait_idle();
    check_count("memory writes", mem_writes - wr_base, 1);
    check_count("stale read memory reads", mem_reads - rd_base, 0);
    flush_cache();
    rd_base = mem_reads;
    send_req(32'h0000_0044, 1'b0, '0);
    wait_idle();
    check_count("refill after flush reads", mem_reads - rd_base, 4);
    report_test("write, stale read, flush");

    @(posedge clk_i);
    bp_en = 1'b1;
    @(negedge clk_i);
    for (int n = 0; n < NumRandom; n++) begin
      stim_rng = lcg_next(stim_rng);
      addr     = {22'd0, stim_rng[25:18], 2'b00};
      is_wr    = (stim_rng[31:30] == 2'b00);
      if (stim_rng[5:3] == 3'd0) begin
        @(negedge clk_i);
      end
      stim_rng = lcg_next(stim_rng);
      send_req(addr, is_wr, stim_rng);
    end
    wait_idle();
    check_count("read responses", rsp_cnt, rd_sent);
    report_test("random traffic");

    @(posedge clk_i);
    bp_en = 1'b0;
    @(negedge clk_i);
    rd_base = mem_reads;
    send_req(32'h0000_0048, 1'b0, '0);
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!rsp_valid_o && lat < 16);
    @(negedge clk_i);
    wait_idle();
    check_count("hit latency", lat, 2);
    check_count("hit memory reads", mem_reads - rd_base, 0);
    report_test("hit latency");

    $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/ro_cache_assert.sv ====
module ro_cache_assert (
  input logic                clk_i,
  input logic                rst_i,
  input logic                flush_valid_i,
  input logic                flush_ready_o,
  input logic                rsp_valid_o,
  input logic                rsp_ready_i,
  input ro_cache_pkg::data_t rsp_data_o,
  input logic                mem_req_valid_o,
  input logic                mem_req_ready_i,
  input ro_cache_pkg::addr_t mem_req_addr_o,
  input logic                mem_req_write_o,
  input ro_cache_pkg::data_t mem_req_wdata_o
);

  // --------------------
  // Handshake stability
  // --------------------
  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
    else $error("rsp_valid_o dropped or rsp_data_o changed before rsp_ready_i");

  // Write data only matters for writes
  mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
      $stable(mem_req_addr_o) && $stable(mem_req_write_o) &&
      (!mem_req_write_o || $stable(mem_req_wdata_o)))
    else $error("mem_req_valid_o dropped or payload changed before mem_req_ready_i");

  flush_ready_only_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_ready_o |-> flush_valid_i)
    else $error("flush_ready_o high without flush_valid_i");

  // Registers are cleared from the second reset cycle on
  no_rsp_in_reset: assert property (@(posedge clk_i)
    rst_i ##1 rst_i |-> !rsp_valid_o)
    else $error("rsp_valid_o high during reset");

endmodule

bind ro_cache_top ro_cache_assert i_assert (.*);

// ==== src/ro_cache_top.sv ====
module ro_cache_top #(
  parameter int unsigned LineCount   = 16,
  parameter int unsigned NrAddrRules = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  enable_i,
  input  ro_cache_pkg::addr_t [NrAddrRules-1:0] start_addr_i,
  input  ro_cache_pkg::addr_t [NrAddrRules-1:0] end_addr_i,
  input  logic                                  flush_valid_i,
  output logic                                  flush_ready_o,
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  ro_cache_pkg::addr_t                   req_addr_i,
  input  logic                                  req_write_i,
  input  ro_cache_pkg::data_t                   req_wdata_i,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output ro_cache_pkg::data_t                   rsp_data_o,
  output logic                                  mem_req_valid_o,
  input  logic                                  mem_req_ready_i,
  output ro_cache_pkg::addr_t                   mem_req_addr_o,
  output logic                                  mem_req_write_o,
  output ro_cache_pkg::data_t                   mem_req_wdata_o,
  input  logic                                  mem_rsp_valid_i,
  input  ro_cache_pkg::data_t                   mem_rsp_data_i
);

  // Select to lookup
  logic                sel_valid;
  logic                sel_ready;
  ro_cache_pkg::addr_u sel_addr;
  logic                sel_write;
  ro_cache_pkg::data_t sel_wdata;
  logic                sel_bypass;

  // Lookup to refill
  logic                lk_valid;
  logic                lk_ready;
  ro_cache_pkg::addr_u lk_addr;
  logic                lk_write;
  ro_cache_pkg::data_t lk_wdata;
  logic                lk_bypass;
  logic                lk_hit;
  ro_cache_pkg::data_t lk_data;

  // Refill back into the arrays
  logic                                   fill_valid;
  logic [ro_cache_pkg::LineAddrWidth-1:0] fill_addr;
  ro_cache_pkg::line_t                    fill_line;

  ro_cache_select #(
    .NrAddrRules ( NrAddrRules )
  ) i_select (
    .clk_i,
    .rst_i,
    .enable_i,
    .start_addr_i,
    .end_addr_i,
    .req_valid_i,
    .req_ready_o,
    .req_addr_i,
    .req_write_i,
    .req_wdata_i,
    .sel_valid_o  ( sel_valid  ),
    .sel_ready_i  ( sel_ready  ),
    .sel_addr_o   ( sel_addr   ),
    .sel_write_o  ( sel_write  ),
    .sel_wdata_o  ( sel_wdata  ),
    .sel_bypass_o ( sel_bypass )
  );

  ro_cache_lookup #(
    .LineCount ( LineCount )
  ) i_lookup (
    .clk_i,
    .rst_i,
    .flush_valid_i,
    .flush_ready_o,
    .sel_valid_i  ( sel_valid  ),
    .sel_ready_o  ( sel_ready  ),
    .sel_addr_i   ( sel_addr   ),
    .sel_write_i  ( sel_write  ),
    .sel_wdata_i  ( sel_wdata  ),
    .sel_bypass_i ( sel_bypass ),
    .lk_valid_o   ( lk_valid   ),
    .lk_ready_i   ( lk_ready   ),
    .lk_addr_o    ( lk_addr    ),
    .lk_write_o   ( lk_write   ),
    .lk_wdata_o   ( lk_wdata   ),
    .lk_bypass_o  ( lk_bypass  ),
    .lk_hit_o     ( lk_hit     ),
    .lk_data_o    ( lk_data    ),
    .fill_valid_i ( fill_valid ),
    .fill_addr_i  ( fill_addr  ),
    .fill_line_i  ( fill_line  )
  );

  ro_cache_refill #(
    .LineCount ( LineCount )
  ) i_refill (
    .clk_i,
    .rst_i,
    .lk_valid_i   ( lk_valid   ),
    .lk_ready_o   ( lk_ready   ),
    .lk_addr_i    ( lk_addr    ),
    .lk_write_i   ( lk_write   ),
    .lk_wdata_i   ( lk_wdata   ),
    .lk_bypass_i  ( lk_bypass  ),
    .lk_hit_i     ( lk_hit     ),
    .lk_data_i    ( lk_data    ),
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_data_o,
    .fill_valid_o ( fill_valid ),
    .fill_addr_o  ( fill_addr  ),
    .fill_line_o  ( fill_line  ),
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_req_addr_o,
    .mem_req_write_o,
    .mem_req_wdata_o,
    .mem_rsp_valid_i,
    .mem_rsp_data_i
  );

endmodule

// ==== src/ro_cache_refill.sv ====
module ro_cache_refill #(
  parameter int unsigned LineCount = 16
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     lk_valid_i,
  output logic                                     lk_ready_o,
  input  ro_cache_pkg::addr_u                      lk_addr_i,
  input  logic                                     lk_write_i,
  input  ro_cache_pkg::data_t                      lk_wdata_i,
  input  logic                                     lk_bypass_i,
  input  logic                                     lk_hit_i,
  input  ro_cache_pkg::data_t                      lk_data_i,
  output logic                                     rsp_valid_o,
  input  logic                                     rsp_ready_i,
  output ro_cache_pkg::data_t                      rsp_data_o,
  output logic                                     fill_valid_o,
  output logic [ro_cache_pkg::LineAddrWidth-1:0]   fill_addr_o,
  output ro_cache_pkg::line_t                      fill_line_o,
  output logic                                     mem_req_valid_o,
  input  logic                                     mem_req_ready_i,
  output ro_cache_pkg::addr_t                      mem_req_addr_o,
  output logic                                     mem_req_write_o,
  output ro_cache_pkg::data_t                      mem_req_wdata_o,
  input  logic                                     mem_rsp_valid_i,
  input  ro_cache_pkg::data_t                      mem_rsp_data_i
);

  if (LineCount < 2 || (LineCount & (LineCount - 1)) != 0) begin : gen_line_count_check
    $error("LineCount must be a power of two of at least 2");
  end

  localparam int unsigned    CntWidth = ro_cache_pkg::WordBits + 1;
  localparam logic [CntWidth-1:0] CntFull = CntWidth'(ro_cache_pkg::LineWords);
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(ro_cache_pkg::LineWords - 1);

  // FSM encoding
  localparam logic [2:0] StIdle   = 3'd0;
  localparam logic [2:0] StWrite  = 3'd1;
  localparam logic [2:0] StBypass = 3'd2;
  localparam logic [2:0] StMiss   = 3'd3;
  localparam logic [2:0] StFill   = 3'd4;
  localparam logic [2:0] StResp   = 3'd5;

  logic [2:0]          state_q, state_d;
  logic [CntWidth-1:0] req_cnt_q;
  logic [CntWidth-1:0] rsp_cnt_q;
  ro_cache_pkg::addr_u addr_q;
  ro_cache_pkg::addr_u mem_addr;
  ro_cache_pkg::data_t wdata_q;
  ro_cache_pkg::data_t rsp_data_q;
  ro_cache_pkg::line_t line_q;

  // Hits are answered straight from the lookup stage
  assign lk_ready_o  = (state_q == StIdle) && (!lk_hit_i || rsp_ready_i);
  assign rsp_valid_o = ((state_q == StIdle) && lk_valid_i && lk_hit_i) ||
                       (state_q == StFill) || (state_q == StResp);
  assign rsp_data_o  = (state_q == StIdle) ? lk_data_i : rsp_data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (lk_valid_i && !lk_hit_i) begin
          if (lk_write_i) begin
            state_d = StWrite;
          end else if (lk_bypass_i) begin
            state_d = StBypass;
          end else begin
            state_d = StMiss;
          end
        end
      end
      StWrite:  if (mem_req_ready_i) state_d = StIdle;
      StBypass: if (mem_rsp_valid_i) state_d = StResp;
      StMiss:   if (mem_rsp_valid_i && rsp_cnt_q == CntLast) state_d = StFill;
      StFill:   state_d = rsp_ready_i ? StIdle : StResp;
      StResp:   if (rsp_ready_i) state_d = StIdle;
      default:  state_d = StIdle;
    endcase
  end

  // --------------------
  // Memory port
  // --------------------
  always_comb begin
    mem_req_valid_o = 1'b0;
    mem_req_write_o = 1'b0;
    mem_addr        = addr_q;
    case (state_q)
      StWrite: begin
        mem_req_valid_o = 1'b1;
        mem_req_write_o = 1'b1;
      end
      StBypass: mem_req_valid_o = (req_cnt_q == '0);
      StMiss: begin
        mem_req_valid_o          = (req_cnt_q != CntFull);
        mem_addr.fields.word     = req_cnt_q[ro_cache_pkg::WordBits-1:0];
        mem_addr.fields.byte_ofs = '0;
      end
      default: mem_req_valid_o = 1'b0;
    endcase
  end

  assign mem_req_addr_o  = mem_addr.raw;
  assign mem_req_wdata_o = wdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= StIdle;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == StIdle) begin
        req_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (mem_req_valid_o && mem_req_ready_i) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (mem_rsp_valid_i) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
      end
    end
  end

  // Capture the item and gather returning words
  always_ff @(posedge clk_i) begin
    if (lk_valid_i && lk_ready_o && !lk_hit_i) begin
      addr_q  <= lk_addr_i;
      wdata_q <= lk_wdata_i;
    end
    if (mem_rsp_valid_i && state_q == StBypass) begin
      rsp_data_q <= mem_rsp_data_i;
    end
    if (mem_rsp_valid_i && state_q == StMiss) begin
      line_q[rsp_cnt_q[ro_cache_pkg::WordBits-1:0]] <= mem_rsp_data_i;
      if (rsp_cnt_q[ro_cache_pkg::WordBits-1:0] == addr_q.fields.word) begin
        rsp_data_q <= mem_rsp_data_i;
      end
    end
  end

  assign fill_valid_o = (state_q == StFill);
  assign fill_addr_o  = addr_q.fields.line_addr;
  assign fill_line_o  = line_q;

endmodule

// ==== src/ro_cache_lookup.sv ====
module ro_cache_lookup #(
  parameter int unsigned LineCount = 16
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     flush_valid_i,
  output logic                                     flush_ready_o,
  input  logic                                     sel_valid_i,
  output logic                                     sel_ready_o,
  input  ro_cache_pkg::addr_u                      sel_addr_i,
  input  logic                                     sel_write_i,
  input  ro_cache_pkg::data_t                      sel_wdata_i,
  input  logic                                     sel_bypass_i,
  output logic                                     lk_valid_o,
  input  logic                                     lk_ready_i,
  output ro_cache_pkg::addr_u                      lk_addr_o,
  output logic                                     lk_write_o,
  output ro_cache_pkg::data_t                      lk_wdata_o,
  output logic                                     lk_bypass_o,
  output logic                                     lk_hit_o,
  output ro_cache_pkg::data_t                      lk_data_o,
  input  logic                                     fill_valid_i,
  input  logic [ro_cache_pkg::LineAddrWidth-1:0]   fill_addr_i,
  input  ro_cache_pkg::line_t                      fill_line_i
);

  localparam int unsigned IndexBits = $clog2(LineCount);
  localparam int unsigned TagBits   = ro_cache_pkg::LineAddrWidth - IndexBits;

  // --------------------
  // Cache arrays
  // --------------------
  logic [LineCount-1:0] valid_q;
  logic [TagBits-1:0]   tag_q  [LineCount];
  ro_cache_pkg::line_t  data_q [LineCount];

  logic [IndexBits-1:0] sel_index;
  logic [TagBits-1:0]   sel_tag;
  logic [IndexBits-1:0] fill_index;
  logic [TagBits-1:0]   fill_tag;
  logic                 accept;
  logic                 flush_done;
  logic                 fill_match;
  logic                 lk_valid_q;

  assign sel_index  = sel_addr_i.fields.line_addr[IndexBits-1:0];
  assign sel_tag    = sel_addr_i.fields.line_addr[ro_cache_pkg::LineAddrWidth-1:IndexBits];
  assign fill_index = fill_addr_i[IndexBits-1:0];
  assign fill_tag   = fill_addr_i[ro_cache_pkg::LineAddrWidth-1:IndexBits];

  // Flush waits for an empty stage
  assign flush_ready_o = flush_valid_i && !lk_valid_q;
  assign flush_done    = flush_valid_i && flush_ready_o;

  // No new item during a fill or while a flush is pending
  assign sel_ready_o = (!lk_valid_q || lk_ready_i) && !fill_valid_i && !flush_valid_i;
  assign accept      = sel_valid_i && sel_ready_o;

  // Held item that just got its line from the refill
  assign fill_match = fill_valid_i && lk_valid_q && !lk_bypass_o &&
                      (fill_addr_i == lk_addr_o.fields.line_addr);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else if (flush_done) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_q[fill_index]  <= fill_tag;
      data_q[fill_index] <= fill_line_i;
    end
  end

  // --------------------
  // Output stage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lk_valid_q <= 1'b0;
    end else begin
      if (lk_ready_i) begin
        lk_valid_q <= 1'b0;
      end
      if (accept) begin
        lk_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      lk_addr_o   <= sel_addr_i;
      lk_write_o  <= sel_write_i;
      lk_wdata_o  <= sel_wdata_i;
      lk_bypass_o <= sel_bypass_i;
      lk_hit_o    <= !sel_bypass_i && valid_q[sel_index] && (tag_q[sel_index] == sel_tag);
      lk_data_o   <= data_q[sel_index][sel_addr_i.fields.word];
    end else if (fill_match) begin
      lk_hit_o  <= 1'b1;
      lk_data_o <= fill_line_i[lk_addr_o.fields.word];
    end
  end

  assign lk_valid_o = lk_valid_q;

endmodule

// ==== src/ro_cache_select.sv ====
module ro_cache_select #(
  parameter int unsigned NrAddrRules = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       enable_i,
  input  ro_cache_pkg::addr_t [NrAddrRules-1:0]      start_addr_i,
  input  ro_cache_pkg::addr_t [NrAddrRules-1:0]      end_addr_i,
  input  logic                                       req_valid_i,
  output logic                                       req_ready_o,
  input  ro_cache_pkg::addr_t                        req_addr_i,
  input  logic                                       req_write_i,
  input  ro_cache_pkg::data_t                        req_wdata_i,
  output logic                                       sel_valid_o,
  input  logic                                       sel_ready_i,
  output ro_cache_pkg::addr_u                        sel_addr_o,
  output logic                                       sel_write_o,
  output ro_cache_pkg::data_t                        sel_wdata_o,
  output logic                                       sel_bypass_o
);

  ro_cache_pkg::addr_u req_addr;
  logic                in_region;
  logic                bypass;
  logic                valid_q;

  assign req_addr.raw = req_addr_i;

  // Region decode with an exclusive end address
  always_comb begin
    in_region = 1'b0;
    for (int unsigned i = 0; i < NrAddrRules; i++) begin
      if (req_addr.raw >= start_addr_i[i] && req_addr.raw < end_addr_i[i]) begin
        in_region = 1'b1;
      end
    end
  end

  assign bypass = req_write_i || !enable_i || !in_region;

  // Stage frees up when empty or draining this cycle
  assign req_ready_o = !valid_q || sel_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      sel_addr_o   <= req_addr;
      sel_write_o  <= req_write_i;
      sel_wdata_o  <= req_wdata_i;
      sel_bypass_o <= bypass;
    end
  end

  assign sel_valid_o = valid_q;

endmodule

// ==== src/ro_cache_pkg.sv ====
package ro_cache_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LineWords = 4;

  // Address field widths
  localparam int unsigned ByteBits      = $clog2(DataWidth / 8);
  localparam int unsigned WordBits      = $clog2(LineWords);
  localparam int unsigned LineAddrWidth = AddrWidth - WordBits - ByteBits;

  // --------------------
  // Types
  // --------------------
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Word 0 sits in the low bits
  typedef data_t [LineWords-1:0] line_t;

  typedef struct packed {
    logic [LineAddrWidth-1:0] line_addr;
    logic [WordBits-1:0]      word;
    logic [ByteBits-1:0]      byte_ofs;
  } addr_fields_t;

  // One address word, seen either raw or split into fields
  typedef union packed {
    addr_t        raw;
    addr_fields_t fields;
  } addr_u;

endpackage
